/* Bender.yml */
package:
  name: fx3_bridge

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fx3_pkg.sv
      - verilog/fwft_fifo.sv
      - fx3_ctrl/fx3_slave_fsm.sv
      - fx3_ctrl/fx3_timers.sv
      - verilog/fx3_ingress.sv
      - verilog/fx3_bridge_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/fx3_bridge_properties.sv
      - tb/fx3_bridge_tb.sv

/* common/fx3_macros.svh */
/* FX3 slave-FIFO bridge constants
   Bus width, buffer sizes, endpoint addresses, timeouts and read latency */

`ifndef FX3_MACROS_SVH
`define FX3_MACROS_SVH

// FX3 data bus width, also the user word width
`define FX3_WIDTH 32

// Depth of each first-word-fall-through buffer
`define FX3_BUF_DEPTH 16

// Free ingress slots left when reads must stop
// Covers the read latency plus the drain words
`define FX3_IN_MARGIN 6

// Socket addresses on fx3_a
`define FX3_EPIN  2'b00
`define FX3_EPOUT 2'b11

// Idle cycles before a zero-length packet is sent
`define FX3_FLUSH_TIMEOUT 10000

// Retry wait before a single-word transfer
`define FX3_SWRW_WAIT 15

// Cycles from a read strobe to valid data on the bus
`define FX3_RD_LATENCY 2

`endif

/* common/fx3_pkg.sv */
/* Shared types of the FX3 bridge
   Transfer states, decoded flags, bus strobes and timer handshake */

package fx3_pkg;

   typedef enum logic [4:0] {
      ST_IDLE,
      ST_FLG_C_RCVD,
      ST_WAIT_FLG_D,
      ST_READ,
      ST_SW_READ,
      ST_READ_DRAIN_1,
      ST_READ_DRAIN_2,
      ST_READ_DRAIN_3,
      ST_READ_DRAIN_4,
      ST_READ_DRAIN_5,
      ST_FLG_A_RCVD,
      ST_WAIT_FLG_B,
      ST_WRITE,
      ST_WRITE_DRAIN_1,
      ST_WRITE_DRAIN_2,
      ST_WRITE_FLUSH,
      ST_SW_WRITE,
      ST_SW_WRITE_WAIT
   } fx3_state_e;

   // FX3 flags after inversion, all active high
   typedef struct packed {
      logic in_full;
      logic in_almost_full;
      logic out_empty;
      logic out_almost_empty;
   } fx3_flags_t;

   // Bus controls before they go onto the active-low pins
   typedef struct packed {
      logic       oe;
      logic       rd;
      logic       wr;
      logic       pktend;
      logic [1:0] addr;
   } fx3_strobes_t;

   // Single-cycle requests from the FSM to the timers
   typedef struct packed {
      logic arm_idle;
      logic clear_idle;
      logic arm_swrw;
      logic arm_swrw_short;
      logic clear_flush;
   } fx3_timer_ctrl_t;

   typedef struct packed {
      logic flush;
      logic swrw_expire;
      logic swrw_short_expire;
   } fx3_timer_stat_t;

endpackage

/* fx3_ctrl/fx3_slave_fsm.sv */
/* FX3 slave-FIFO transfer FSM
   Arbitrates host writes, flushes and reads and drives the bus strobes */

`timescale 1ns/1ps
`include "fx3_macros.svh"

module fx3_slave_fsm (
   input  logic                     fx3_pclk,
   input  logic                     int_rst,
   input  fx3_pkg::fx3_flags_t      flags,
   input  logic                     in_almost_full,
   input  logic                     egress_empty,
   input  fx3_pkg::fx3_timer_stat_t tstat,
   output fx3_pkg::fx3_strobes_t    strobes,
   output logic                     egress_pop,
   output fx3_pkg::fx3_timer_ctrl_t tctrl
);

   fx3_pkg::fx3_state_e state;
   fx3_pkg::fx3_state_e nxt_state;

   always_ff @(posedge fx3_pclk or posedge int_rst) begin
      if (int_rst) begin
         state <= fx3_pkg::ST_IDLE;
      end else begin
         state <= nxt_state;
      end
   end

   always_comb begin
      nxt_state  = state;
      strobes    = '{oe: 1'b0, rd: 1'b0, wr: 1'b0, pktend: 1'b0, addr: `FX3_EPIN};
      egress_pop = 1'b0;
      tctrl      = '0;

      case (state)
         fx3_pkg::ST_IDLE: begin
            // Writes first, then a pending flush, then reads
            if (!flags.in_full && !egress_empty) begin
               nxt_state = fx3_pkg::ST_FLG_A_RCVD;
            end else if (tstat.flush) begin
               nxt_state = fx3_pkg::ST_WRITE_FLUSH;
            end else if (!flags.out_empty && !in_almost_full) begin
               nxt_state = fx3_pkg::ST_FLG_C_RCVD;
            end
         end

         fx3_pkg::ST_FLG_A_RCVD: begin
            tctrl.clear_idle  = 1'b1;
            tctrl.clear_flush = 1'b1;
            tctrl.arm_swrw    = 1'b1;
            nxt_state         = fx3_pkg::ST_WAIT_FLG_B;
         end

         fx3_pkg::ST_WAIT_FLG_B: begin
            if (flags.in_full) begin
               tctrl.arm_idle = 1'b1;
               nxt_state      = fx3_pkg::ST_IDLE;
            end else if (!flags.in_almost_full) begin
               nxt_state = fx3_pkg::ST_WRITE;
            end else if (tstat.swrw_expire) begin
               nxt_state = fx3_pkg::ST_SW_WRITE;
            end
         end

         fx3_pkg::ST_WRITE: begin
            if (egress_empty) begin
               tctrl.arm_idle = 1'b1;
               nxt_state      = fx3_pkg::ST_IDLE;
            end else begin
               strobes.wr = 1'b1;
               egress_pop = 1'b1;
               if (flags.in_almost_full) begin
                  nxt_state = fx3_pkg::ST_WRITE_DRAIN_1;
               end
            end
         end

         fx3_pkg::ST_WRITE_DRAIN_1: begin
            strobes.wr = 1'b1;
            egress_pop = 1'b1;
            nxt_state  = fx3_pkg::ST_WRITE_DRAIN_2;
         end

         fx3_pkg::ST_WRITE_DRAIN_2: begin
            strobes.wr     = 1'b1;
            egress_pop     = 1'b1;
            tctrl.arm_idle = 1'b1;
            nxt_state      = fx3_pkg::ST_IDLE;
         end

         fx3_pkg::ST_SW_WRITE: begin
            strobes.wr           = 1'b1;
            egress_pop           = 1'b1;
            tctrl.arm_swrw_short = 1'b1;
            nxt_state            = fx3_pkg::ST_SW_WRITE_WAIT;
         end

         // Give the FX3 time to update its flags after the single word
         fx3_pkg::ST_SW_WRITE_WAIT: begin
            if (tstat.swrw_short_expire) begin
               tctrl.arm_idle = 1'b1;
               nxt_state      = fx3_pkg::ST_IDLE;
            end
         end

         fx3_pkg::ST_WRITE_FLUSH: begin
            strobes.pktend    = ~flags.in_full;
            tctrl.clear_flush = 1'b1;
            nxt_state         = fx3_pkg::ST_IDLE;
         end

         fx3_pkg::ST_FLG_C_RCVD: begin
            strobes.addr   = `FX3_EPOUT;
            tctrl.arm_swrw = 1'b1;
            nxt_state      = fx3_pkg::ST_WAIT_FLG_D;
         end

         fx3_pkg::ST_WAIT_FLG_D: begin
            strobes.addr = `FX3_EPOUT;
            if (!flags.out_almost_empty) begin
               nxt_state = fx3_pkg::ST_READ;
            end else if (tstat.swrw_expire) begin
               nxt_state = fx3_pkg::ST_SW_READ;
            end
         end

         fx3_pkg::ST_READ: begin
            strobes.addr = `FX3_EPOUT;
            strobes.rd   = 1'b1;
            strobes.oe   = 1'b1;
            // Ingress nearly full skips the extra reads
            if (in_almost_full) begin
               nxt_state = fx3_pkg::ST_READ_DRAIN_4;
            end else if (flags.out_almost_empty) begin
               nxt_state = fx3_pkg::ST_READ_DRAIN_1;
            end
         end

         fx3_pkg::ST_SW_READ: begin
            strobes.addr = `FX3_EPOUT;
            strobes.rd   = 1'b1;
            strobes.oe   = 1'b1;
            nxt_state    = fx3_pkg::ST_READ_DRAIN_4;
         end

         fx3_pkg::ST_READ_DRAIN_1,
         fx3_pkg::ST_READ_DRAIN_2,
         fx3_pkg::ST_READ_DRAIN_3: begin
            strobes.addr = `FX3_EPOUT;
            strobes.rd   = 1'b1;
            strobes.oe   = 1'b1;
            nxt_state    = fx3_pkg::fx3_state_e'(state + 5'd1);
         end

         // Output enable held while the last words come out of the pipe
         fx3_pkg::ST_READ_DRAIN_4: begin
            strobes.addr = `FX3_EPOUT;
            strobes.oe   = 1'b1;
            nxt_state    = fx3_pkg::ST_READ_DRAIN_5;
         end

         fx3_pkg::ST_READ_DRAIN_5: begin
            strobes.addr = `FX3_EPOUT;
            strobes.oe   = 1'b1;
            nxt_state    = fx3_pkg::ST_IDLE;
         end

         default: begin
            nxt_state = fx3_pkg::ST_IDLE;
         end
      endcase
   end

endmodule

/* fx3_ctrl/fx3_timers.sv */
/* Timers of the FX3 transfer FSM
   Idle-flush timeout with its flush flag, and the single-word retry counter */

`timescale 1ns/1ps
`include "fx3_macros.svh"

module fx3_timers (
   input  logic                     fx3_pclk,
   input  logic                     int_rst,
   input  fx3_pkg::fx3_timer_ctrl_t tctrl,
   output fx3_pkg::fx3_timer_stat_t tstat
);

   localparam int IDLE_W = $clog2(`FX3_FLUSH_TIMEOUT + 1);
   localparam int SWRW_W = $clog2(`FX3_SWRW_WAIT + 1);

   logic [IDLE_W-1:0] idle_cnt;
   logic [SWRW_W-1:0] swrw_cnt;
   logic              flush;

   always_ff @(posedge fx3_pclk or posedge int_rst) begin
      if (int_rst) begin
         idle_cnt <= '0;
         swrw_cnt <= '0;
         // One zero-length packet goes out after reset
         flush    <= 1'b1;
      end else begin
         if (tctrl.clear_idle) begin
            idle_cnt <= '0;
         end else if (tctrl.arm_idle) begin
            idle_cnt <= IDLE_W'(`FX3_FLUSH_TIMEOUT);
         end else if (idle_cnt != '0) begin
            idle_cnt <= idle_cnt - 1'b1;
         end

         if (tctrl.arm_swrw) begin
            swrw_cnt <= SWRW_W'(`FX3_SWRW_WAIT);
         end else if (tctrl.arm_swrw_short) begin
            swrw_cnt <= SWRW_W'(3);
         end else if (swrw_cnt != '0) begin
            swrw_cnt <= swrw_cnt - 1'b1;
         end

         if (tctrl.clear_flush) begin
            flush <= 1'b0;
         end else if (idle_cnt == IDLE_W'(1)) begin
            flush <= 1'b1;
         end
      end
   end

   assign tstat.flush       = flush;
   assign tstat.swrw_expire = (swrw_cnt == SWRW_W'(1));
   // Short wait ends one cycle ahead, when the next count is one
   assign tstat.swrw_short_expire = (swrw_cnt == SWRW_W'(2));

endmodule

/* sim.f */
+incdir+common
common/fx3_pkg.sv
verilog/fwft_fifo.sv
fx3_ctrl/fx3_slave_fsm.sv
fx3_ctrl/fx3_timers.sv
verilog/fx3_ingress.sv
verilog/fx3_bridge_top.sv
tb/fx3_bridge_properties.sv
tb/fx3_bridge_tb.sv

/* tb/fx3_bridge_properties.sv */
/* Protocol assertions for the FX3 bridge
   Bound into the top level to watch the strobes and the bus direction */

`timescale 1ns/1ps
`include "fx3_macros.svh"

module fx3_bridge_properties (
   input logic                  fx3_pclk,
   input logic                  int_rst,
   input fx3_pkg::fx3_strobes_t strobes
);

   int unsigned fail_count = 0;

   // One bus, so never a read and a write in the same cycle
   rd_wr_exclusive: assert property (@(posedge fx3_pclk) disable iff (int_rst)
      !(strobes.rd && strobes.wr))
   else begin
      fail_count++;
      $error("rd and wr strobes asserted together");
   end

   // The FX3 drives the bus under oe, so the bridge must have let go
   oe_bus_released: assert property (@(posedge fx3_pclk) disable iff (int_rst)
      strobes.oe |-> (strobes.addr != `FX3_EPIN))
   else begin
      fail_count++;
      $error("bus driven by the bridge while the FX3 output is enabled");
   end

   // Write data only goes out toward the host-bound socket
   wr_bus_driven: assert property (@(posedge fx3_pclk) disable iff (int_rst)
      strobes.wr |-> (strobes.addr == `FX3_EPIN))
   else begin
      fail_count++;
      $error("write strobe while the bus is not driven by the bridge");
   end

   pktend_single: assert property (@(posedge fx3_pclk) disable iff (int_rst)
      strobes.pktend |=> !strobes.pktend)
   else begin
      fail_count++;
      $error("pktend held for more than one cycle");
   end

endmodule

bind fx3_bridge_top fx3_bridge_properties props_i (
   .fx3_pclk (fx3_pclk),
   .int_rst  (int_rst),
   .strobes  (strobes)
);

/* tb/fx3_bridge_tb.sv */
/* Testbench for the FX3 slave-FIFO bridge
   FX3 host model with directed ingress, egress, back-pressure and flush tests */

`timescale 1ns/1ps
`include "fx3_macros.svh"

module fx3_bridge_tb;

   localparam int CYCLE_LIMIT = 60 + 200 + 200 + 400 + 200 + 200 + 2 * `FX3_FLUSH_TIMEOUT;
   localparam int ALMOST_LVL  = 4;

   logic                  fx3_pclk = 1'b0;
   logic                  rst;
   wire [`FX3_WIDTH-1:0]  fx3_dq;
   logic                  fx3_slcs_n;
   logic                  fx3_sloe_n;
   logic                  fx3_slrd_n;
   logic                  fx3_slwr_n;
   logic                  fx3_pktend_n;
   logic [1:0]            fx3_a;
   logic                  fx3_flaga_n = 1'b1;
   logic                  fx3_flagb_n = 1'b1;
   logic                  fx3_flagc_n;
   logic                  fx3_flagd_n;
   logic                  fx3_com_rst;
   logic                  fx3_logic_rst;
   logic                  fifo_out_valid;
   logic                  fifo_out_ready;
   logic [`FX3_WIDTH-1:0] fifo_out_data;
   logic                  fifo_in_valid;
   logic                  fifo_in_ready;
   logic [`FX3_WIDTH-1:0] fifo_in_data;
   logic                  ctrl_logic_rst;
   logic                  com_rst;

   // Host model state
   logic [`FX3_WIDTH-1:0] host_out_q[$];
   logic [`FX3_WIDTH-1:0] host_in_q[$];
   logic [`FX3_WIDTH-1:0] rd_word = '0;
   logic [`FX3_WIDTH-1:0] bus_drv = '0;
   logic [2:0]            empty_pipe = 3'b111;
   logic [2:0]            aempty_pipe = 3'b111;
   int                    in_space;
   int                    wr_cyc_q[$];
   int                    last_wr_cyc = 0;
   int                    last_pkt_cyc = 0;
   int                    pktend_count = 0;

   // User side and bookkeeping
   logic [`FX3_WIDTH-1:0] tx_q[$];
   logic [`FX3_WIDTH-1:0] rx_q[$];
   logic [`FX3_WIDTH-1:0] exp_q[$];
   int                    cyc = 0;
   int                    errors = 0;

   fx3_bridge_top dut_i (.*);

   always #4 fx3_pclk = ~fx3_pclk;

   // Host drives the bus only while the host-sourced socket is selected
   assign fx3_dq      = (fx3_a == `FX3_EPOUT) ? bus_drv : {`FX3_WIDTH{1'bz}};
   // Read flags lag the queue by the three-cycle capture path
   assign fx3_flagc_n = ~empty_pipe[2];
   assign fx3_flagd_n = ~aempty_pipe[2];

   always @(posedge fx3_pclk) begin
      empty_pipe  <= {empty_pipe[1:0], host_out_q.size() == 0};
      aempty_pipe <= {aempty_pipe[1:0], host_out_q.size() <= 2};
      fx3_flaga_n <= (in_space != 0);
      fx3_flagb_n <= (in_space > ALMOST_LVL);
      // Word appears on the bus two cycles after its rd
      bus_drv     <= rd_word;
      rd_word     <= '0;
      if (!fx3_slrd_n && host_out_q.size() > 0) begin
         rd_word <= host_out_q.pop_front();
      end
      if (!fx3_slwr_n) begin
         host_in_q.push_back(fx3_dq);
         wr_cyc_q.push_back(cyc);
         last_wr_cyc <= cyc;
      end
      if (!fx3_pktend_n) begin
         pktend_count <= pktend_count + 1;
         last_pkt_cyc <= cyc;
      end
   end

   always @(posedge fx3_pclk) begin
      if (fifo_in_valid && fifo_in_ready) begin
         rx_q.push_back(fifo_in_data);
      end
   end

   always @(posedge fx3_pclk) begin
      cyc <= cyc + 1;
      if (cyc >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Summary: %0d check errors, %0d assertion failures", errors,
                  dut_i.props_i.fail_count);
         $display("Regression failed");
         $finish;
      end
   end

   task automatic compare(input string what, input logic [31:0] got,
                          input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic wait_words(input bit to_host, input int n, input int limit);
      int waited;
      waited = 0;
      while (((to_host ? host_in_q.size() : rx_q.size()) < n) && (waited < limit)) begin
         @(posedge fx3_pclk);
         waited++;
      end
      if ((to_host ? host_in_q.size() : rx_q.size()) < n) begin
         errors++;
         $display("Waited %0d cycles and %0d words did not all arrive", limit, n);
      end
   endtask

   task automatic check_stream(input string what, input bit to_host);
      int                    n;
      int                    i;
      logic [`FX3_WIDTH-1:0] got;
      n = to_host ? host_in_q.size() : rx_q.size();
      compare({what, " word count"}, n, exp_q.size());
      for (i = 0; i < exp_q.size() && i < n; i++) begin
         got = to_host ? host_in_q[i] : rx_q[i];
         compare(what, got, exp_q[i]);
      end
   endtask

   task automatic load_host_words(input int n);
      logic [`FX3_WIDTH-1:0] w;
      @(negedge fx3_pclk);
      exp_q.delete();
      rx_q.delete();
      repeat (n) begin
         w = $urandom;
         exp_q.push_back(w);
         host_out_q.push_back(w);
      end
      @(posedge fx3_pclk);
   endtask

   task automatic load_user_words(input int n);
      logic [`FX3_WIDTH-1:0] w;
      @(negedge fx3_pclk);
      exp_q.delete();
      host_in_q.delete();
      wr_cyc_q.delete();
      repeat (n) begin
         w = $urandom;
         exp_q.push_back(w);
         tx_q.push_back(w);
      end
      @(posedge fx3_pclk);
   endtask

   // Valid/ready source for the egress side
   task automatic send_user_words();
      while (tx_q.size() > 0) begin
         fifo_out_valid <= 1'b1;
         fifo_out_data  <= tx_q[0];
         @(posedge fx3_pclk);
         if (fifo_out_ready) begin
            void'(tx_q.pop_front());
         end
      end
      fifo_out_valid <= 1'b0;
   endtask

   task automatic check_reset_state();
      repeat (2) @(posedge fx3_pclk);
      compare("sloe_n in reset", fx3_sloe_n, 1'b1);
      compare("slrd_n in reset", fx3_slrd_n, 1'b1);
      compare("slwr_n in reset", fx3_slwr_n, 1'b1);
      compare("pktend_n in reset", fx3_pktend_n, 1'b1);
      compare("address in reset", fx3_a, `FX3_EPIN);
      compare("slcs_n tied low", fx3_slcs_n, 1'b0);
      compare("com_rst in reset", com_rst, 1'b1);
      compare("logic reset pass-through low", ctrl_logic_rst, 1'b0);
      // FX3 side reset alone keeps the bridge in reset
      rst           <= 1'b0;
      fx3_com_rst   <= 1'b1;
      fx3_logic_rst <= 1'b1;
      @(posedge fx3_pclk);
      compare("com_rst from the FX3 reset", com_rst, 1'b1);
      compare("logic reset pass-through high", ctrl_logic_rst, 1'b1);
      fx3_com_rst   <= 1'b0;
      fx3_logic_rst <= 1'b0;
      @(posedge fx3_pclk);
      compare("com_rst after reset", com_rst, 1'b0);
      repeat (40) @(posedge fx3_pclk);
      compare("pktend pulses after reset", pktend_count, 1);
   endtask

   task automatic stream_ingress();
      fifo_in_ready <= 1'b1;
      load_host_words(20);
      wait_words(1'b0, 20, 200);
      repeat (10) @(posedge fx3_pclk);
      check_stream("ingress word", 1'b0);
   endtask

   task automatic stream_egress();
      load_user_words(20);
      send_user_words();
      wait_words(1'b1, 20, 200);
      repeat (10) @(posedge fx3_pclk);
      check_stream("egress word", 1'b1);
   endtask

   task automatic stall_ingress();
      fifo_in_ready <= 1'b0;
      load_host_words(40);
      repeat (150) @(posedge fx3_pclk);
      compare("words delivered while stalled", rx_q.size(), 0);
      compare("reads stopped at the margin", host_out_q.size() >= 40 - `FX3_BUF_DEPTH, 1);
      compare("ingress valid while stalled", fifo_in_valid, 1'b1);
      fifo_in_ready <= 1'b1;
      wait_words(1'b0, 40, 400);
      repeat (10) @(posedge fx3_pclk);
      check_stream("stalled ingress word", 1'b0);
   endtask

   task automatic single_word_writes();
      int i;
      @(negedge fx3_pclk);
      in_space = 2;
      load_user_words(4);
      send_user_words();
      wait_words(1'b1, 4, 200);
      check_stream("single-word write", 1'b1);
      for (i = 1; i < wr_cyc_q.size(); i++) begin
         compare("retry spacing", (wr_cyc_q[i] - wr_cyc_q[i-1]) >= `FX3_SWRW_WAIT, 1);
      end
      @(negedge fx3_pclk);
      in_space = 1024;
      repeat (4) @(posedge fx3_pclk);
   endtask

   task automatic idle_flush();
      int pk_before;
      int waited;
      int delay;
      pk_before = pktend_count;
      load_user_words(8);
      send_user_words();
      wait_words(1'b1, 8, 200);
      check_stream("flush burst word", 1'b1);
      compare("pktend during traffic", pktend_count, pk_before);
      waited = 0;
      while ((pktend_count == pk_before) && (waited < `FX3_FLUSH_TIMEOUT + 100)) begin
         @(posedge fx3_pclk);
         waited++;
      end
      repeat (20) @(posedge fx3_pclk);
      compare("pktend pulses after idle", pktend_count, pk_before + 1);
      delay = last_pkt_cyc - last_wr_cyc;
      compare("flush delay in window", (delay >= `FX3_FLUSH_TIMEOUT) &&
              (delay <= `FX3_FLUSH_TIMEOUT + 4), 1);
   endtask

   initial begin
      void'($urandom(32'hf56f6911));
      rst            = 1'b1;
      fx3_com_rst    = 1'b0;
      fx3_logic_rst  = 1'b0;
      fifo_out_valid = 1'b0;
      fifo_out_data  = '0;
      fifo_in_ready  = 1'b1;
      in_space       = 1024;
      check_reset_state();
      stream_ingress();
      stream_egress();
      stall_ingress();
      single_word_writes();
      idle_flush();
      repeat (5) @(posedge fx3_pclk);
      $display("Summary: %0d check errors, %0d assertion failures", errors,
               dut_i.props_i.fail_count);
      if ((errors == 0) && (dut_i.props_i.fail_count == 0)) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* verilog/fwft_fifo.sv */
/* Synchronous first-word-fall-through FIFO
   Head word always on dout, almost_full at a programmable free-slot margin */

`timescale 1ns/1ps
`include "fx3_macros.svh"

module fwft_fifo #(
   parameter int DEPTH  = 16,
   parameter int MARGIN = 1
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [`FX3_WIDTH-1:0] din,
   input  logic                  wr_en,
   output logic                  full,
   output logic                  almost_full,
   output logic [`FX3_WIDTH-1:0] dout,
   output logic                  empty,
   input  logic                  rd_en
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [`FX3_WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [CNT_W-1:0]      count;
   logic                  do_wr;
   logic                  do_rd;

   // Requests against a full or empty buffer are dropped
   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   assign full        = (count == CNT_W'(DEPTH));
   assign empty       = (count == '0);
   assign almost_full = (count >= CNT_W'(DEPTH - MARGIN));
   assign dout        = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leave the fill level unchanged
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

/* verilog/fx3_bridge_top.sv */
/* FX3 slave-FIFO bridge top level
   Connects the FX3 bus to user valid/ready streams in the fx3_pclk domain */

`timescale 1ns/1ps
`include "fx3_macros.svh"

module fx3_bridge_top (
   input  logic                  fx3_pclk,
   input  logic                  rst,
   inout  wire [`FX3_WIDTH-1:0]  fx3_dq,
   output logic                  fx3_slcs_n,
   output logic                  fx3_sloe_n,
   output logic                  fx3_slrd_n,
   output logic                  fx3_slwr_n,
   output logic                  fx3_pktend_n,
   output logic [1:0]            fx3_a,
   input  logic                  fx3_flaga_n,
   input  logic                  fx3_flagb_n,
   input  logic                  fx3_flagc_n,
   input  logic                  fx3_flagd_n,
   input  logic                  fx3_com_rst,
   input  logic                  fx3_logic_rst,
   input  logic                  fifo_out_valid,
   output logic                  fifo_out_ready,
   input  logic [`FX3_WIDTH-1:0] fifo_out_data,
   output logic                  fifo_in_valid,
   input  logic                  fifo_in_ready,
   output logic [`FX3_WIDTH-1:0] fifo_in_data,
   output logic                  ctrl_logic_rst,
   output logic                  com_rst
);

   logic                     int_rst;
   fx3_pkg::fx3_flags_t      flags;
   fx3_pkg::fx3_strobes_t    strobes;
   fx3_pkg::fx3_timer_ctrl_t tctrl;
   fx3_pkg::fx3_timer_stat_t tstat;
   logic                     in_almost_full;
   logic                     egress_empty;
   logic                     egress_full;
   logic                     egress_pop;
   logic [`FX3_WIDTH-1:0]    egress_dout;

   // Host-side communication reset also resets the user side
   assign int_rst        = rst | fx3_com_rst;
   assign com_rst        = int_rst;
   assign ctrl_logic_rst = fx3_logic_rst;

   assign flags.in_full          = ~fx3_flaga_n;
   assign flags.in_almost_full   = ~fx3_flagb_n;
   assign flags.out_empty        = ~fx3_flagc_n;
   assign flags.out_almost_empty = ~fx3_flagd_n;

   assign fx3_slcs_n   = 1'b0;
   assign fx3_sloe_n   = ~strobes.oe;
   assign fx3_slrd_n   = ~strobes.rd;
   assign fx3_slwr_n   = ~strobes.wr;
   assign fx3_pktend_n = ~strobes.pktend;
   assign fx3_a        = strobes.addr;

   // Drive the bus only toward the host-bound socket
   assign fx3_dq = (strobes.addr == `FX3_EPIN) ? egress_dout : {`FX3_WIDTH{1'bz}};

   fx3_slave_fsm fsm_i (
      .fx3_pclk       (fx3_pclk),
      .int_rst        (int_rst),
      .flags          (flags),
      .in_almost_full (in_almost_full),
      .egress_empty   (egress_empty),
      .tstat          (tstat),
      .strobes        (strobes),
      .egress_pop     (egress_pop),
      .tctrl          (tctrl)
   );

   fx3_timers timers_i (
      .fx3_pclk (fx3_pclk),
      .int_rst  (int_rst),
      .tctrl    (tctrl),
      .tstat    (tstat)
   );

   fx3_ingress ingress_i (
      .fx3_pclk       (fx3_pclk),
      .int_rst        (int_rst),
      .rd             (strobes.rd),
      .out_empty      (flags.out_empty),
      .dq_in          (fx3_dq),
      .in_almost_full (in_almost_full),
      .fifo_in_valid  (fifo_in_valid),
      .fifo_in_ready  (fifo_in_ready),
      .fifo_in_data   (fifo_in_data)
   );

   fwft_fifo #(
      .DEPTH  (`FX3_BUF_DEPTH),
      .MARGIN (1)
   ) egress_buf_i (
      .clk         (fx3_pclk),
      .rst         (int_rst),
      .din         (fifo_out_data),
      .wr_en       (fifo_out_valid & ~egress_full),
      .full        (egress_full),
      .almost_full (),
      .dout        (egress_dout),
      .empty       (egress_empty),
      .rd_en       (egress_pop)
   );

   assign fifo_out_ready = ~egress_full;

endmodule

/* verilog/fx3_ingress.sv */
/* Host-to-user data path
   Aligns the read strobe with the bus latency and buffers captured words */

`timescale 1ns/1ps
`include "fx3_macros.svh"

module fx3_ingress (
   input  logic                  fx3_pclk,
   input  logic                  int_rst,
   input  logic                  rd,
   input  logic                  out_empty,
   input  logic [`FX3_WIDTH-1:0] dq_in,
   output logic                  in_almost_full,
   output logic                  fifo_in_valid,
   input  logic                  fifo_in_ready,
   output logic [`FX3_WIDTH-1:0] fifo_in_data
);

   localparam int LAT = `FX3_RD_LATENCY;

   logic [LAT-1:0]        rd_dly;
   logic                  cap_valid;
   logic [`FX3_WIDTH-1:0] dq_q;
   logic                  buf_empty;

   // Strobe delay matches the FX3 read latency
   always_ff @(posedge fx3_pclk or posedge int_rst) begin
      if (int_rst) begin
         rd_dly    <= '0;
         cap_valid <= 1'b0;
      end else begin
         rd_dly    <= (rd_dly << 1) | LAT'(rd);
         cap_valid <= rd_dly[LAT-1];
      end
   end

   always_ff @(posedge fx3_pclk) begin
      dq_q <= dq_in;
   end

   fwft_fifo #(
      .DEPTH  (`FX3_BUF_DEPTH),
      .MARGIN (`FX3_IN_MARGIN)
   ) ingress_buf_i (
      .clk         (fx3_pclk),
      .rst         (int_rst),
      .din         (dq_q),
      .wr_en       (cap_valid & ~out_empty),
      .full        (),
      .almost_full (in_almost_full),
      .dout        (fifo_in_data),
      .empty       (buf_empty),
      .rd_en       (fifo_in_ready)
   );

   assign fifo_in_valid = ~buf_empty;

endmodule
